//--- logic/fft_pkg.sv
`default_nettype none

package fft_pkg;

    // ------------------------------
    // data widths
    // ------------------------------

    // one real or imaginary part
    localparam int DATA_W  = 16;
    // twiddles are Q1.14
    localparam int TW_FRAC = 14;

    typedef logic signed [DATA_W-1:0] part_t;

    // real part in the upper half, imaginary part in the lower half
    typedef logic [2*DATA_W-1:0] sample_t;

    // ------------------------------
    // stage controller
    // ------------------------------

    typedef enum logic [1:0] {
        IDLE,
        READ_A,
        READ_B,
        DRAIN
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/sample_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_buffer #(
    parameter int LOG2N = 4
) (
    input  wire                   clk,
    input  wire                   we_i,
    input  wire [LOG2N-1:0]       wr_addr_i,
    input  wire fft_pkg::sample_t wr_data_i,
    input  wire                   rd_en_i,
    input  wire [LOG2N-1:0]       rd_addr_i,
    output fft_pkg::sample_t      rd_data_o
);
    import fft_pkg::*;

    localparam int N = 1 << LOG2N;

    sample_t mem [N];

    // load port from outside
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read answers one cycle after the request
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- logic/result_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module result_buffer #(
    parameter int LOG2N = 4
) (
    input  wire                   clk,
    input  wire                   we_i,
    input  wire [LOG2N-1:0]       wr_addr1_i,
    input  wire fft_pkg::sample_t wr_data1_i,
    input  wire [LOG2N-1:0]       wr_addr2_i,
    input  wire fft_pkg::sample_t wr_data2_i,
    input  wire [LOG2N-1:0]       rd_addr_i,
    output fft_pkg::sample_t      rd_data_o
);
    import fft_pkg::*;

    localparam int N = 1 << LOG2N;

    sample_t mem [N];

    // ------------------------------
    // write back
    // ------------------------------

    // sum and difference of one pair land together,
    // the two addresses of a pair never match
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_addr1_i] <= wr_data1_i;
            mem[wr_addr2_i] <= wr_data2_i;
        end
    end

    // dump port, always reading
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

//--- logic/twiddle_rom.sv
`timescale 1ns/1ps
`default_nettype none

module twiddle_rom #(
    parameter int LOG2N = 4
) (
    input  wire              clk,
    input  wire              rd_en_i,
    input  wire [LOG2N-2:0]  idx_i,
    output fft_pkg::sample_t tw_o
);
    import fft_pkg::*;

    localparam int  N      = 1 << LOG2N;
    localparam int  HALF_N = N / 2;
    localparam int  ONE_Q  = 1 << TW_FRAC;
    localparam real PI     = 3.14159265358979323846;

    typedef sample_t table_t [HALF_N];

    // W^m = cos(2*pi*m/N) - j*sin(2*pi*m/N) in Q1.14
    function automatic table_t build_table();
        table_t t;
        real    ang;
        int     re;
        int     im;
        for (int m = 0; m < HALF_N; m++) begin
            ang = 2.0 * PI * m / N;
            re  = int'($cos(ang) * ONE_Q);
            im  = int'(-$sin(ang) * ONE_Q);
            // +1.0 does not fit in Q1.14
            if (re > ONE_Q - 1) begin
                re = ONE_Q - 1;
            end
            t[m] = {part_t'(re), part_t'(im)};
        end
        return t;
    endfunction

    localparam table_t TW_TABLE = build_table();

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            tw_o <= TW_TABLE[idx_i];
        end
    end

endmodule

`default_nettype wire

//--- logic/butterfly_unit.sv
`timescale 1ns/1ps
`default_nettype none

module butterfly_unit #(
    parameter int LOG2N = 4
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   en_rd_i,
    input  wire fft_pkg::sample_t data_i,
    input  wire fft_pkg::sample_t tw_i,
    input  wire [LOG2N-1:0]       adr_ptr1_i,
    input  wire [LOG2N-1:0]       adr_ptr2_i,
    output logic                  pair_done_o,
    output logic [LOG2N-1:0]      adr_ptr1_o,
    output logic [LOG2N-1:0]      adr_ptr2_o,
    output fft_pkg::sample_t      sum_o,
    output fft_pkg::sample_t      diff_o
);
    import fft_pkg::*;

    logic               rd_phase;
    logic               en_d;
    logic               phase_d;
    logic               take_a;
    logic               take_b;
    sample_t            a_q;
    sample_t            tw_q;
    logic [LOG2N-1:0]   ptr1_q;
    logic [LOG2N-1:0]   ptr2_q;
    part_t              a_re;
    part_t              a_im;
    part_t              b_re;
    part_t              b_im;
    part_t              w_re;
    part_t              w_im;
    logic signed [31:0] acc_re;
    logic signed [31:0] acc_im;
    part_t              p_re;
    part_t              p_im;

    // returning word is A or B depending on the request phase
    assign take_a = en_d && !phase_d;
    assign take_b = en_d && phase_d;

    assign a_re = a_q[2*DATA_W-1:DATA_W];
    assign a_im = a_q[DATA_W-1:0];
    assign w_re = tw_q[2*DATA_W-1:DATA_W];
    assign w_im = tw_q[DATA_W-1:0];
    // B is used straight off the buffer output
    assign b_re = data_i[2*DATA_W-1:DATA_W];
    assign b_im = data_i[DATA_W-1:0];

    // ------------------------------
    // complex product B*W
    // ------------------------------

    assign acc_re = b_re * w_re - b_im * w_im;
    assign acc_im = b_re * w_im + b_im * w_re;
    assign p_re   = part_t'(acc_re >>> TW_FRAC);
    assign p_im   = part_t'(acc_im >>> TW_FRAC);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_phase    <= 1'b0;
            en_d        <= 1'b0;
            phase_d     <= 1'b0;
            pair_done_o <= 1'b0;
        end else begin
            en_d        <= en_rd_i;
            phase_d     <= rd_phase;
            pair_done_o <= take_b;
            if (en_rd_i) begin
                rd_phase <= ~rd_phase;
            end
        end
    end

    always_ff @(posedge clk) begin
        // addresses ride along from the A request
        if (en_rd_i && !rd_phase) begin
            ptr1_q <= adr_ptr1_i;
            ptr2_q <= adr_ptr2_i;
        end
        if (take_a) begin
            a_q  <= data_i;
            tw_q <= tw_i;
        end
        // sums wrap at 16 bits
        if (take_b) begin
            sum_o      <= {part_t'(a_re + p_re), part_t'(a_im + p_im)};
            diff_o     <= {part_t'(a_re - p_re), part_t'(a_im - p_im)};
            adr_ptr1_o <= ptr1_q;
            adr_ptr2_o <= ptr2_q;
        end
    end

endmodule

`default_nettype wire

//--- logic/fft_stage_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fft_stage_ctrl #(
    parameter int LOG2N = 4,
    parameter int STAGE = 1
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              start_i,
    input  wire              pair_done_i,
    input  wire [LOG2N-1:0]  adr_ptr1_i,
    input  wire [LOG2N-1:0]  adr_ptr2_i,
    output logic             en_rd_o,
    output logic [LOG2N-1:0] rd_ptr_o,
    output logic             en_tw_o,
    output logic [LOG2N-2:0] tw_idx_o,
    output logic [LOG2N-1:0] adr_ptr1_o,
    output logic [LOG2N-1:0] adr_ptr2_o,
    output logic             en_wr_o,
    output logic [LOG2N-1:0] wr_ptr1_o,
    output logic [LOG2N-1:0] wr_ptr2_o,
    output logic             done_o
);
    import fft_pkg::*;

    localparam int N        = 1 << LOG2N;
    localparam int HALF     = 1 << STAGE;
    localparam int TW_SHIFT = LOG2N - 1 - STAGE;

    ctrl_state_t      state;
    logic [LOG2N-2:0] pair_cnt;
    logic [LOG2N-1:0] pair_ext;
    logic [LOG2N-2:0] k_off;
    logic [LOG2N-1:0] addr_a;
    logic [LOG2N-1:0] addr_b;
    logic [LOG2N-1:0] wr_cnt;
    logic             launch;

    // ------------------------------
    // pair addressing
    // ------------------------------

    // group base is g*2*half, offset k is p mod half
    assign pair_ext = {1'b0, pair_cnt};
    assign k_off    = pair_cnt & (LOG2N-1)'(HALF - 1);
    assign addr_a   = ((pair_ext >> STAGE) << (STAGE + 1)) | {1'b0, k_off};
    assign addr_b   = addr_a + LOG2N'(HALF);

    assign launch = (state == IDLE) && start_i;

    // read requests follow the state directly
    assign en_rd_o    = (state == READ_A) || (state == READ_B);
    assign rd_ptr_o   = (state == READ_B) ? addr_b : addr_a;
    assign en_tw_o    = (state == READ_A);
    // twiddle step is N / (2*half)
    assign tw_idx_o   = k_off << TW_SHIFT;
    assign adr_ptr1_o = addr_a;
    assign adr_ptr2_o = addr_b;

    // ------------------------------
    // read sequencer
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            pair_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        pair_cnt <= '0;
                        state    <= READ_A;
                    end
                end
                READ_A: begin
                    state <= READ_B;
                end
                READ_B: begin
                    pair_cnt <= pair_cnt + 1'b1;
                    // last pair of the stage has all ones
                    if (&pair_cnt) begin
                        state <= DRAIN;
                    end else begin
                        state <= READ_A;
                    end
                end
                DRAIN: begin
                    if (wr_cnt == LOG2N'(N / 2)) begin
                        done_o <= 1'b1;
                        state  <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // write-back
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_wr_o <= 1'b0;
            wr_cnt  <= '0;
        end else begin
            en_wr_o <= pair_done_i;
            if (launch) begin
                wr_cnt <= '0;
            end else if (en_wr_o) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // pointers of the pair that just finished
    always_ff @(posedge clk) begin
        if (pair_done_i) begin
            wr_ptr1_o <= adr_ptr1_i;
            wr_ptr2_o <= adr_ptr2_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/fft_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module fft_stage_top #(
    parameter int LOG2N = 4,
    parameter int STAGE = 1
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   load_we_i,
    input  wire [LOG2N-1:0]       load_addr_i,
    input  wire fft_pkg::sample_t load_data_i,
    input  wire                   start_i,
    input  wire [LOG2N-1:0]       dump_addr_i,
    output logic                  done_o,
    output fft_pkg::sample_t      dump_data_o
);
    import fft_pkg::*;

    logic             en_rd;
    logic [LOG2N-1:0] rd_ptr;
    logic             en_tw;
    logic [LOG2N-2:0] tw_idx;
    logic [LOG2N-1:0] rd_adr1;
    logic [LOG2N-1:0] rd_adr2;
    logic             pair_done;
    logic [LOG2N-1:0] bf_adr1;
    logic [LOG2N-1:0] bf_adr2;
    logic             en_wr;
    logic [LOG2N-1:0] wr_ptr1;
    logic [LOG2N-1:0] wr_ptr2;
    sample_t          rd_data;
    sample_t          tw;
    sample_t          bf_sum;
    sample_t          bf_diff;

    // ------------------------------
    // controller
    // ------------------------------

    fft_stage_ctrl #(
        .LOG2N (LOG2N),
        .STAGE (STAGE)
    ) i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .pair_done_i (pair_done),
        .adr_ptr1_i  (bf_adr1),
        .adr_ptr2_i  (bf_adr2),
        .en_rd_o     (en_rd),
        .rd_ptr_o    (rd_ptr),
        .en_tw_o     (en_tw),
        .tw_idx_o    (tw_idx),
        .adr_ptr1_o  (rd_adr1),
        .adr_ptr2_o  (rd_adr2),
        .en_wr_o     (en_wr),
        .wr_ptr1_o   (wr_ptr1),
        .wr_ptr2_o   (wr_ptr2),
        .done_o      (done_o)
    );

    // ------------------------------
    // datapath
    // ------------------------------

    sample_buffer #(.LOG2N(LOG2N)) i_sample_buffer (
        .clk       (clk),
        .we_i      (load_we_i),
        .wr_addr_i (load_addr_i),
        .wr_data_i (load_data_i),
        .rd_en_i   (en_rd),
        .rd_addr_i (rd_ptr),
        .rd_data_o (rd_data)
    );

    twiddle_rom #(.LOG2N(LOG2N)) i_twiddle_rom (
        .clk     (clk),
        .rd_en_i (en_tw),
        .idx_i   (tw_idx),
        .tw_o    (tw)
    );

    butterfly_unit #(.LOG2N(LOG2N)) i_butterfly (
        .clk         (clk),
        .rst_n       (rst_n),
        .en_rd_i     (en_rd),
        .data_i      (rd_data),
        .tw_i        (tw),
        .adr_ptr1_i  (rd_adr1),
        .adr_ptr2_i  (rd_adr2),
        .pair_done_o (pair_done),
        .adr_ptr1_o  (bf_adr1),
        .adr_ptr2_o  (bf_adr2),
        .sum_o       (bf_sum),
        .diff_o      (bf_diff)
    );

    result_buffer #(.LOG2N(LOG2N)) i_result_buffer (
        .clk        (clk),
        .we_i       (en_wr),
        .wr_addr1_i (wr_ptr1),
        .wr_data1_i (bf_sum),
        .wr_addr2_i (wr_ptr2),
        .wr_data2_i (bf_diff),
        .rd_addr_i  (dump_addr_i),
        .rd_data_o  (dump_data_o)
    );

endmodule

`default_nettype wire

//--- verif/fft_stage_model.svh
`ifndef FFT_STAGE_MODEL_SVH
`define FFT_STAGE_MODEL_SVH

// ------------------------------
// pair and twiddle rules
// ------------------------------

// operand A of pair p, B sits one half span above it
function automatic int pair_addr_a(input int p, input int stage);
    int half;
    half = 1 << stage;
    return (p / half) * 2 * half + p % half;
endfunction

function automatic int pair_twiddle_index(input int p, input int log2n, input int stage);
    int half;
    half = 1 << stage;
    return (p % half) * ((1 << log2n) / (2 * half));
endfunction

// round half away from zero
function automatic int round_real(input real x);
    if (x >= 0.0) begin
        return $rtoi($floor(x + 0.5));
    end
    return -$rtoi($floor(0.5 - x));
endfunction

// W^m in Q1.14, +1.0 clipped to the largest code
function automatic sample_t twiddle_value(input int m, input int log2n);
    real ang;
    int  re;
    int  im;
    ang = 6.283185307179586 * m / (1 << log2n);
    re  = round_real($cos(ang) * 16384.0);
    im  = round_real(-$sin(ang) * 16384.0);
    if (re > 16383) begin
        re = 16383;
    end
    return {re[15:0], im[15:0]};
endfunction

// ------------------------------
// butterfly arithmetic
// ------------------------------

function automatic sample_t complex_mul(input sample_t b, input sample_t w);
    int br;
    int bi;
    int wr;
    int wi;
    int acc_re;
    int acc_im;
    br     = $signed(b[31:16]);
    bi     = $signed(b[15:0]);
    wr     = $signed(w[31:16]);
    wi     = $signed(w[15:0]);
    acc_re = (br * wr - bi * wi) >>> 14;
    acc_im = (br * wi + bi * wr) >>> 14;
    return {acc_re[15:0], acc_im[15:0]};
endfunction

// both halves wrap at 16 bits
function automatic sample_t bfly_sum(input sample_t a, input sample_t bw);
    logic [15:0] re;
    logic [15:0] im;
    re = a[31:16] + bw[31:16];
    im = a[15:0] + bw[15:0];
    return {re, im};
endfunction

function automatic sample_t bfly_diff(input sample_t a, input sample_t bw);
    logic [15:0] re;
    logic [15:0] im;
    re = a[31:16] - bw[31:16];
    im = a[15:0] - bw[15:0];
    return {re, im};
endfunction

`endif

//--- verif/fft_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fft_stage_tb;
    import fft_pkg::*;

    `include "fft_stage_model.svh"

    localparam int LOG2N       = 4;
    localparam int STAGE       = 1;
    localparam int N           = 1 << LOG2N;
    localparam int CLK_NS      = 8;
    localparam int NUM_ROWS    = 5;
    localparam int MARGIN      = 20;
    // load, run, quiet check after done, dump
    localparam int ROW_CYCLES  = (N + 2) + (N + 5) + N + (N + 1) + MARGIN;
    localparam int RAND_SEED   = 32'h5955_2459;

    localparam int PAT_ZERO    = 0;
    localparam int PAT_IMPULSE = 1;
    localparam int PAT_CONST   = 2;
    localparam int PAT_RANDOM  = 3;
    localparam int PAT_ALT     = 4;

    // stimulus table with pattern, seed offset and an extra start_i during the run
    int row_pattern [NUM_ROWS] = '{PAT_ZERO, PAT_IMPULSE, PAT_CONST, PAT_RANDOM, PAT_ALT};
    int row_offset  [NUM_ROWS] = '{0, 5, 700, 3, 1};
    bit row_restart [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

    logic             clk;
    logic             rst_n;
    logic             load_we;
    logic [LOG2N-1:0] load_addr;
    sample_t          load_data;
    logic             start;
    logic [LOG2N-1:0] dump_addr;
    logic             done;
    sample_t          dump_data;

    sample_t src [N];
    sample_t exp_res [N];

    fft_stage_top #(
        .LOG2N (LOG2N),
        .STAGE (STAGE)
    ) i_fft_stage_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .start_i     (start),
        .dump_addr_i (dump_addr),
        .done_o      (done),
        .dump_data_o (dump_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #((NUM_ROWS * ROW_CYCLES + 10) * CLK_NS);
        $display("timeout: the stage run never finished, done_o did not come in time");
        $display("tests failed");
        $fatal(1);
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic sample_t make_sample(input int pattern, input int idx, input int offset);
        case (pattern)
            PAT_IMPULSE: return (idx == offset) ? {16'h2000, 16'h0000} : '0;
            PAT_CONST:   return {offset[15:0], 16'h0000};
            PAT_RANDOM:  return $urandom() ^ offset;
            PAT_ALT:     return ((idx + offset) % 2 == 0) ? {16'h7fff, 16'h8000}
                                                          : {16'h8000, 16'h7fff};
            default:     return '0;
        endcase
    endfunction

    // ------------------------------
    // per-row steps
    // ------------------------------

    task automatic load_samples(input int row);
        for (int i = 0; i < N; i++) begin
            src[i] = make_sample(row_pattern[row], i, row_offset[row]);
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= LOG2N'(i);
            load_data <= src[i];
            @(negedge clk);
            assert (!done) else report_failure("done_o went high while no stage was running");
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic predict_results();
        int      a;
        int      b;
        sample_t bw;
        for (int p = 0; p < N / 2; p++) begin
            a  = pair_addr_a(p, STAGE);
            b  = a + (1 << STAGE);
            bw = complex_mul(src[b], twiddle_value(pair_twiddle_index(p, LOG2N, STAGE), LOG2N));
            exp_res[a] = bfly_sum(src[a], bw);
            exp_res[b] = bfly_diff(src[a], bw);
        end
    endtask

    task automatic run_stage(input bit restart);
        int cycles;
        cycles = 0;
        @(posedge clk);
        start <= 1'b1;
        while (!done) begin
            @(posedge clk);
            cycles++;
            // a second pulse mid-run must be ignored
            start <= restart && (cycles == 6);
            @(negedge clk);
            assert (cycles <= 2 * N + 5)
                else report_failure("done_o never came after the start_i pulse");
        end
        assert (cycles == N + 5)
            else report_failure($sformatf(
                "MISMATCH at %0t: start-to-done_o cycles got %0d expected %0d",
                $time, cycles, N + 5));
        repeat (N) begin
            @(negedge clk);
            assert (!done) else report_failure("done_o pulsed more than once in one run");
        end
    endtask

    // read address i while checking the word of i-1
    task automatic dump_and_check();
        for (int i = 0; i <= N; i++) begin
            @(posedge clk);
            if (i < N) begin
                dump_addr <= LOG2N'(i);
            end
            @(negedge clk);
            if (i > 0) begin
                assert (dump_data == exp_res[i - 1])
                    else report_failure($sformatf(
                        "MISMATCH at %0t: dump_data_o[%0d] got %08h expected %08h",
                        $time, i - 1, dump_data, exp_res[i - 1]));
            end
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst_n     = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        start     = 1'b0;
        dump_addr = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (!done) else report_failure("done_o high after reset without a start_i pulse");
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            load_samples(r);
            predict_results();
            run_stage(row_restart[r]);
            dump_and_check();
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/fft_pkg.sv
logic/sample_buffer.sv
logic/result_buffer.sv
logic/twiddle_rom.sv
logic/butterfly_unit.sv
logic/fft_stage_ctrl.sv
logic/fft_stage_top.sv
+incdir+verif
verif/fft_stage_tb.sv
